//--- csr_index_mem_pkg.sv
// Memory response widths, engine window constants and response vector types
package csr_index_mem_pkg;

    // ------------------------------------------------------------------------
    // Response word geometry
    // ------------------------------------------------------------------------
    localparam int data_w   = 32;
    localparam int offset_w = 32;

    // One configuration sequence spans this many response words
    localparam int seq_width = 16;
    // Only the leading words carry record fields
    localparam int seq_fields = 8;

    // ------------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------------
    typedef logic [data_w-1:0]    data_word_t;
    typedef logic [offset_w-1:0]  offset_t;

    // One bit per word position inside a sequence
    typedef logic [seq_width-1:0] seq_onehot_t;

endpackage : csr_index_mem_pkg

//--- csr_index_cfg_pkg.sv
// Configuration record field types, FIFO sizing and tracker state encoding
package csr_index_cfg_pkg;

    // ------------------------------------------------------------------------
    // Record field types
    // ------------------------------------------------------------------------
    typedef logic [31:0] index_t;

    // Shift amount, log2 of the 32-bit address width
    typedef logic [4:0]  granularity_t;

    typedef logic [2:0]  memory_cmd_t;
    typedef logic [3:0]  id_channel_t;
    typedef logic [3:0]  id_buffer_t;

    // Five flags, four indices, granularity, direction, cmd and two ids
    localparam int record_w = 5 + 4 * $bits(index_t) + $bits(granularity_t) + 1
                            + $bits(memory_cmd_t) + $bits(id_channel_t)
                            + $bits(id_buffer_t);

    // ------------------------------------------------------------------------
    // Output FIFO
    // ------------------------------------------------------------------------
    localparam int fifo_depth = 16;

    // One extra bit so a full FIFO can be told apart from an empty one
    typedef logic [4:0] fifo_count_t;

    // ------------------------------------------------------------------------
    // Sequence tracker FSM
    // ------------------------------------------------------------------------
    typedef enum logic [1:0] {
        tracker_idle,
        tracker_collect,
        tracker_done
    } tracker_state_t;

endpackage : csr_index_cfg_pkg

//--- csr_index_response_filter.sv
// Response filter that registers memory responses and keeps those inside the engine window
`timescale 1ns/1ps

module csr_index_response_filter #(
    parameter int window_index = 0
) (
    input  logic                          ap_clk,
    input  logic                          areset_csr_index_generator,
    input  logic                          response_valid,
    input  csr_index_mem_pkg::offset_t    response_offset,
    input  csr_index_mem_pkg::data_word_t response_data,
    output logic                          kept_valid,
    output csr_index_mem_pkg::offset_t    kept_offset,
    output csr_index_mem_pkg::data_word_t kept_data
);

    // Window of seq_width offsets owned by this engine
    localparam csr_index_mem_pkg::offset_t window_lo =
        csr_index_mem_pkg::offset_t'(window_index * csr_index_mem_pkg::seq_width);
    localparam csr_index_mem_pkg::offset_t window_hi =
        window_lo + csr_index_mem_pkg::offset_t'(csr_index_mem_pkg::seq_width);

    logic response_valid_q;
    logic in_window;

    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            response_valid_q <= 1'b0;
        end else begin
            response_valid_q <= response_valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        kept_offset <= response_offset;
        kept_data   <= response_data;
    end

    assign in_window  = (kept_offset >= window_lo) && (kept_offset < window_hi);
    assign kept_valid = response_valid_q & in_window;

    // Offset seen one cycle earlier must map onto this engine's window index
    a_kept_in_window : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        kept_valid |-> ($past(response_offset) / csr_index_mem_pkg::seq_width ==
                        csr_index_mem_pkg::offset_t'(window_index)));

endmodule : csr_index_response_filter

//--- csr_index_sequence_tracker.sv
// Sequence tracker, follows the one-hot word position and flags each finished record
`timescale 1ns/1ps

module csr_index_sequence_tracker #(
    parameter int window_index = 0
) (
    input  logic                           ap_clk,
    input  logic                           areset_csr_index_generator,
    input  logic                           kept_valid,
    input  csr_index_mem_pkg::offset_t     kept_offset,
    output csr_index_mem_pkg::seq_onehot_t seq_position,
    output logic                           record_done
);

    localparam csr_index_mem_pkg::offset_t window_base =
        csr_index_mem_pkg::offset_t'(window_index * csr_index_mem_pkg::seq_width);
    localparam csr_index_mem_pkg::seq_onehot_t first_pos = 1;

    csr_index_cfg_pkg::tracker_state_t state;
    logic                              at_base;

    assign at_base = (kept_offset == window_base);

    // ------------------------------------------------------------------------
    // Position FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            state        <= csr_index_cfg_pkg::tracker_idle;
            seq_position <= '0;
            record_done  <= 1'b0;
        end else begin
            // Pulse trails the done state so the decoder has settled
            record_done <= (state == csr_index_cfg_pkg::tracker_done);
            case (state)
                csr_index_cfg_pkg::tracker_idle: begin
                    if (kept_valid && at_base) begin
                        seq_position <= first_pos;
                        state        <= csr_index_cfg_pkg::tracker_collect;
                    end
                end
                csr_index_cfg_pkg::tracker_collect: begin
                    if (kept_valid) begin
                        seq_position <= seq_position << 1;
                        // Word landing on the last position closes the record
                        if (seq_position[csr_index_mem_pkg::seq_width-2]) begin
                            state <= csr_index_cfg_pkg::tracker_done;
                        end
                    end
                end
                default: begin
                    // Back-to-back sequence may start right here
                    if (kept_valid && at_base) begin
                        seq_position <= first_pos;
                        state        <= csr_index_cfg_pkg::tracker_collect;
                    end else begin
                        seq_position <= '0;
                        state        <= csr_index_cfg_pkg::tracker_idle;
                    end
                end
            endcase
        end
    end

    a_position_onehot : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        $onehot0(seq_position));

    a_done_single : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        record_done |=> !record_done);

endmodule : csr_index_sequence_tracker

//--- csr_index_field_decoder.sv
// Field decoder, loads configuration record fields from each sequence position
`timescale 1ns/1ps

module csr_index_field_decoder (
    input  logic                           ap_clk,
    input  logic                           kept_valid,
    input  csr_index_mem_pkg::data_word_t  kept_data,
    input  csr_index_mem_pkg::seq_onehot_t seq_position,
    output logic                           increment,
    output logic                           decrement,
    output logic                           mode_sequence,
    output logic                           mode_buffer,
    output logic                           mode_break,
    output csr_index_cfg_pkg::index_t      index_start,
    output csr_index_cfg_pkg::index_t      index_end,
    output csr_index_cfg_pkg::index_t      stride,
    output csr_index_cfg_pkg::index_t      array_size,
    output csr_index_cfg_pkg::granularity_t granularity,
    output logic                           direction,
    output csr_index_cfg_pkg::memory_cmd_t cmd,
    output csr_index_cfg_pkg::id_channel_t id_channel,
    output csr_index_cfg_pkg::id_buffer_t  id_buffer
);

    // Word is held one cycle so it lines up with the position it was given
    logic                          word_valid_q;
    csr_index_mem_pkg::data_word_t word_q;
    logic                          field_word;

    always_ff @(posedge ap_clk) begin
        word_valid_q <= kept_valid;
        word_q       <= kept_data;
    end

    // Positions past seq_fields carry nothing
    assign field_word = word_valid_q && |seq_position[csr_index_mem_pkg::seq_fields-1:0];

    always_ff @(posedge ap_clk) begin
        if (field_word) begin
            case (1'b1)
                seq_position[0]: begin
                    increment     <= word_q[0];
                    decrement     <= word_q[1];
                    mode_sequence <= word_q[2];
                    mode_buffer   <= word_q[3];
                    mode_break    <= word_q[4];
                end
                seq_position[1]: index_start <= word_q;
                seq_position[2]: index_end   <= word_q;
                seq_position[3]: stride      <= word_q;
                seq_position[4]: begin
                    granularity <= word_q[$bits(csr_index_cfg_pkg::granularity_t)-1:0];
                    direction   <= word_q[csr_index_mem_pkg::data_w-1];
                end
                seq_position[5]: begin
                    cmd        <= word_q[2:0];
                    id_channel <= word_q[7:4];
                end
                seq_position[6]: id_buffer  <= word_q[3:0];
                default:         array_size <= word_q;
            endcase
        end
    end

endmodule : csr_index_field_decoder

//--- csr_index_config_fifo.sv
// Configuration FIFO, 16 finished records with registered pop and registered outputs
`timescale 1ns/1ps

module csr_index_config_fifo (
    input  logic                            ap_clk,
    input  logic                            areset_csr_index_generator,
    input  logic                            wr_en,
    input  logic                            increment,
    input  logic                            decrement,
    input  logic                            mode_sequence,
    input  logic                            mode_buffer,
    input  logic                            mode_break,
    input  csr_index_cfg_pkg::index_t       index_start,
    input  csr_index_cfg_pkg::index_t       index_end,
    input  csr_index_cfg_pkg::index_t       stride,
    input  csr_index_cfg_pkg::index_t       array_size,
    input  csr_index_cfg_pkg::granularity_t granularity,
    input  logic                            direction,
    input  csr_index_cfg_pkg::memory_cmd_t  cmd,
    input  csr_index_cfg_pkg::id_channel_t  id_channel,
    input  csr_index_cfg_pkg::id_buffer_t   id_buffer,
    input  logic                            rd_en,
    output logic                            cfg_increment,
    output logic                            cfg_decrement,
    output logic                            cfg_mode_sequence,
    output logic                            cfg_mode_buffer,
    output logic                            cfg_mode_break,
    output csr_index_cfg_pkg::index_t       cfg_index_start,
    output csr_index_cfg_pkg::index_t       cfg_index_end,
    output csr_index_cfg_pkg::index_t       cfg_stride,
    output csr_index_cfg_pkg::index_t       cfg_array_size,
    output csr_index_cfg_pkg::granularity_t cfg_granularity,
    output logic                            cfg_direction,
    output csr_index_cfg_pkg::memory_cmd_t  cfg_cmd,
    output csr_index_cfg_pkg::id_channel_t  cfg_id_channel,
    output csr_index_cfg_pkg::id_buffer_t   cfg_id_buffer,
    output logic                            cfg_valid,
    output logic                            empty,
    output logic                            full,
    output logic                            setup
);

    localparam int ptr_w = $clog2(csr_index_cfg_pkg::fifo_depth);

    logic [csr_index_cfg_pkg::record_w-1:0] mem [csr_index_cfg_pkg::fifo_depth];
    logic [csr_index_cfg_pkg::record_w-1:0] din;
    logic [csr_index_cfg_pkg::record_w-1:0] rd_data_q;
    logic [csr_index_cfg_pkg::record_w-1:0] dout_q;
    logic [ptr_w-1:0]                       wr_ptr;
    logic [ptr_w-1:0]                       rd_ptr;
    csr_index_cfg_pkg::fifo_count_t         count;
    logic                                   rd_en_q;
    logic                                   rd_valid_q;
    logic                                   push;
    logic                                   pop;

    assign din = {increment, decrement, mode_sequence, mode_buffer, mode_break,
                  index_start, index_end, stride, array_size, granularity,
                  direction, cmd, id_channel, id_buffer};

    assign empty = (count == '0);
    assign full  = (count == csr_index_cfg_pkg::fifo_count_t'(csr_index_cfg_pkg::fifo_depth));
    // Records arriving while full are lost
    assign push  = wr_en & ~full;
    assign pop   = rd_en_q & ~empty;

    // ------------------------------------------------------------------------
    // Control
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_csr_index_generator) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            rd_en_q    <= 1'b0;
            rd_valid_q <= 1'b0;
            cfg_valid  <= 1'b0;
            setup      <= 1'b1;
        end else begin
            rd_en_q    <= rd_en;
            rd_valid_q <= pop;
            cfg_valid  <= rd_valid_q;
            setup      <= 1'b0;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Storage and read data
    // ------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
        if (pop) begin
            rd_data_q <= mem[rd_ptr];
        end
        dout_q <= rd_data_q;
    end

    assign {cfg_increment, cfg_decrement, cfg_mode_sequence, cfg_mode_buffer,
            cfg_mode_break, cfg_index_start, cfg_index_end, cfg_stride,
            cfg_array_size, cfg_granularity, cfg_direction, cfg_cmd,
            cfg_id_channel, cfg_id_buffer} = dout_q;

    a_count_bound : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator)
        count <= csr_index_cfg_pkg::fifo_count_t'(csr_index_cfg_pkg::fifo_depth));

endmodule : csr_index_config_fifo

//--- csr_index_configure_memory.sv
// CSR index configuration loader, turns in-window response words into queued records
`timescale 1ns/1ps

module csr_index_configure_memory #(
    parameter int window_index = 0
) (
    input  logic                            ap_clk,
    input  logic                            areset_csr_index_generator,
    input  logic                            response_valid,
    input  csr_index_mem_pkg::offset_t      response_offset,
    input  csr_index_mem_pkg::data_word_t   response_data,
    input  logic                            cfg_rd_en,
    output logic                            cfg_valid,
    output logic                            cfg_increment,
    output logic                            cfg_decrement,
    output logic                            cfg_mode_sequence,
    output logic                            cfg_mode_buffer,
    output logic                            cfg_mode_break,
    output csr_index_cfg_pkg::index_t       cfg_index_start,
    output csr_index_cfg_pkg::index_t       cfg_index_end,
    output csr_index_cfg_pkg::index_t       cfg_stride,
    output csr_index_cfg_pkg::index_t       cfg_array_size,
    output csr_index_cfg_pkg::granularity_t cfg_granularity,
    output logic                            cfg_direction,
    output csr_index_cfg_pkg::memory_cmd_t  cfg_cmd,
    output csr_index_cfg_pkg::id_channel_t  cfg_id_channel,
    output csr_index_cfg_pkg::id_buffer_t   cfg_id_buffer,
    output logic                            fifo_empty,
    output logic                            fifo_full,
    output logic                            fifo_setup
);

    // ------------------------------------------------------------------------
    // Internal wires
    // ------------------------------------------------------------------------
    logic                            kept_valid;
    csr_index_mem_pkg::offset_t      kept_offset;
    csr_index_mem_pkg::data_word_t   kept_data;
    csr_index_mem_pkg::seq_onehot_t  seq_position;
    logic                            record_done;
    logic                            increment;
    logic                            decrement;
    logic                            mode_sequence;
    logic                            mode_buffer;
    logic                            mode_break;
    csr_index_cfg_pkg::index_t       index_start;
    csr_index_cfg_pkg::index_t       index_end;
    csr_index_cfg_pkg::index_t       stride;
    csr_index_cfg_pkg::index_t       array_size;
    csr_index_cfg_pkg::granularity_t granularity;
    logic                            direction;
    csr_index_cfg_pkg::memory_cmd_t  cmd;
    csr_index_cfg_pkg::id_channel_t  id_channel;
    csr_index_cfg_pkg::id_buffer_t   id_buffer;

    csr_index_response_filter #(
        .window_index(window_index)
    ) u_filter (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .response_valid            (response_valid),
        .response_offset           (response_offset),
        .response_data             (response_data),
        .kept_valid                (kept_valid),
        .kept_offset               (kept_offset),
        .kept_data                 (kept_data)
    );

    csr_index_sequence_tracker #(
        .window_index(window_index)
    ) u_tracker (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .kept_valid                (kept_valid),
        .kept_offset               (kept_offset),
        .seq_position              (seq_position),
        .record_done               (record_done)
    );

    csr_index_field_decoder u_decoder (
        .ap_clk       (ap_clk),
        .kept_valid   (kept_valid),
        .kept_data    (kept_data),
        .seq_position (seq_position),
        .increment    (increment),
        .decrement    (decrement),
        .mode_sequence(mode_sequence),
        .mode_buffer  (mode_buffer),
        .mode_break   (mode_break),
        .index_start  (index_start),
        .index_end    (index_end),
        .stride       (stride),
        .array_size   (array_size),
        .granularity  (granularity),
        .direction    (direction),
        .cmd          (cmd),
        .id_channel   (id_channel),
        .id_buffer    (id_buffer)
    );

    csr_index_config_fifo u_fifo (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator),
        .wr_en                     (record_done),
        .increment                 (increment),
        .decrement                 (decrement),
        .mode_sequence             (mode_sequence),
        .mode_buffer               (mode_buffer),
        .mode_break                (mode_break),
        .index_start               (index_start),
        .index_end                 (index_end),
        .stride                    (stride),
        .array_size                (array_size),
        .granularity               (granularity),
        .direction                 (direction),
        .cmd                       (cmd),
        .id_channel                (id_channel),
        .id_buffer                 (id_buffer),
        .rd_en                     (cfg_rd_en),
        .cfg_increment             (cfg_increment),
        .cfg_decrement             (cfg_decrement),
        .cfg_mode_sequence         (cfg_mode_sequence),
        .cfg_mode_buffer           (cfg_mode_buffer),
        .cfg_mode_break            (cfg_mode_break),
        .cfg_index_start           (cfg_index_start),
        .cfg_index_end             (cfg_index_end),
        .cfg_stride                (cfg_stride),
        .cfg_array_size            (cfg_array_size),
        .cfg_granularity           (cfg_granularity),
        .cfg_direction             (cfg_direction),
        .cfg_cmd                   (cfg_cmd),
        .cfg_id_channel            (cfg_id_channel),
        .cfg_id_buffer             (cfg_id_buffer),
        .cfg_valid                 (cfg_valid),
        .empty                     (fifo_empty),
        .full                      (fifo_full),
        .setup                     (fifo_setup)
    );

endmodule : csr_index_configure_memory

//--- tb_clock_gen.sv
// Testbench clock and reset source, free running clock with a reset held for a few cycles
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int half_period  = 50,
    parameter int reset_cycles = 5
) (
    output logic ap_clk,
    output logic areset_csr_index_generator
);

    initial begin
        ap_clk = 1'b0;
        forever #half_period ap_clk = ~ap_clk;
    end

    initial begin
        areset_csr_index_generator = 1'b1;
        repeat (reset_cycles) @(posedge ap_clk);
        areset_csr_index_generator <= 1'b0;
    end

endmodule : tb_clock_gen

//--- tb_csr_index_configure_memory.sv
// CSR index configuration loader testbench driving response sequences and checking records
`timescale 1ns/1ps

module tb_csr_index_configure_memory;

    typedef logic [149:0] record_t;

    logic        ap_clk;
    logic        areset_csr_index_generator;
    logic        response_valid;
    logic [31:0] response_offset;
    logic [31:0] response_data;
    logic        cfg_rd_en;
    logic        cfg_valid, fifo_empty, fifo_full, fifo_setup;
    logic        cfg_increment, cfg_decrement, cfg_mode_sequence, cfg_mode_buffer;
    logic        cfg_mode_break, cfg_direction;
    logic [31:0] cfg_index_start, cfg_index_end, cfg_stride, cfg_array_size;
    logic [4:0]  cfg_granularity;
    logic [2:0]  cfg_cmd;
    logic [3:0]  cfg_id_channel, cfg_id_buffer;
    record_t     actual_rec;

    record_t     exp_q[$];
    record_t     exp_rec;
    string       current_test = "reset";
    logic [31:0] lcg_state = 32'hd6a2d32e;
    int          value_errors = 0;
    int          other_errors = 0;
    int          beats_seen = 0;
    int          done_pulses = 0;
    int          sent_count = 0;

    tb_clock_gen u_clock_gen (
        .ap_clk                    (ap_clk),
        .areset_csr_index_generator(areset_csr_index_generator)
    );

    csr_index_configure_memory #(.window_index(1)) dut (
        .ap_clk(ap_clk), .areset_csr_index_generator(areset_csr_index_generator),
        .response_valid(response_valid), .response_offset(response_offset),
        .response_data(response_data), .cfg_rd_en(cfg_rd_en), .cfg_valid(cfg_valid),
        .cfg_increment(cfg_increment), .cfg_decrement(cfg_decrement),
        .cfg_mode_sequence(cfg_mode_sequence), .cfg_mode_buffer(cfg_mode_buffer),
        .cfg_mode_break(cfg_mode_break), .cfg_index_start(cfg_index_start),
        .cfg_index_end(cfg_index_end), .cfg_stride(cfg_stride),
        .cfg_array_size(cfg_array_size), .cfg_granularity(cfg_granularity),
        .cfg_direction(cfg_direction), .cfg_cmd(cfg_cmd), .cfg_id_channel(cfg_id_channel),
        .cfg_id_buffer(cfg_id_buffer), .fifo_empty(fifo_empty), .fifo_full(fifo_full),
        .fifo_setup(fifo_setup)
    );

    assign actual_rec = {cfg_increment, cfg_decrement, cfg_mode_sequence, cfg_mode_buffer,
                         cfg_mode_break, cfg_index_start, cfg_index_end, cfg_stride,
                         cfg_array_size, cfg_granularity, cfg_direction, cfg_cmd,
                         cfg_id_channel, cfg_id_buffer};

    // ------------------------------------------------------------------------
    // Reference model and random source
    // ------------------------------------------------------------------------
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Word 0 flags, words 1 to 7 fields, words 8 to 15 ignored
    function automatic record_t expected_record(input logic [31:0] w [16]);
        return {w[0][0], w[0][1], w[0][2], w[0][3], w[0][4], w[1], w[2], w[3], w[7],
                w[4][4:0], w[4][31], w[5][2:0], w[5][7:4], w[6][3:0]};
    endfunction

    // ------------------------------------------------------------------------
    // Checkers
    // ------------------------------------------------------------------------
    a_full_excludes_empty : assert property (@(posedge ap_clk)
        disable iff (areset_csr_index_generator) !(fifo_full && fifo_empty))
        else begin
            other_errors++;
            $display("FIFO reports full and empty at the same time in %s", current_test);
        end

    // Outputs are stable at the falling edge
    always @(negedge ap_clk) begin
        if (!areset_csr_index_generator && dut.record_done) begin
            done_pulses++;
        end
        if (!areset_csr_index_generator && cfg_valid) begin
            assert (exp_q.size() > 0) else begin
                other_errors++;
                $display("cfg_valid beat with no record outstanding in %s", current_test);
            end
            if (exp_q.size() > 0) begin
                exp_rec = exp_q.pop_front();
                assert (actual_rec === exp_rec) else begin
                    value_errors++;
                    $display("error %s record: expected %h, actual %h",
                             current_test, exp_rec, actual_rec);
                end
            end
            beats_seen++;
        end
    end

    task automatic expect_bit(input string what, input logic exp, input logic act);
        assert (act === exp) else begin
            value_errors++;
            $display("error %s %s: expected %b, actual %b", current_test, what, exp, act);
        end
    endtask

    // ------------------------------------------------------------------------
    // Stimulus tasks
    // ------------------------------------------------------------------------
    task automatic send_sequence(input bit with_noise);
        logic [31:0] words [16];
        logic [31:0] rnd;
        for (int i = 0; i < 16; i++) begin
            words[i] = next_random();
            @(posedge ap_clk);
            response_valid  <= 1'b1;
            response_offset <= 32'(16 + i);
            response_data   <= words[i];
            rnd = next_random();
            if (with_noise && rnd[0]) begin
                // Foreign word below or above the window
                @(posedge ap_clk);
                response_offset <= rnd[1] ? 32'(rnd[7:4]) : 32'd32 + 32'(rnd[15:8]);
                response_data   <= next_random();
            end
        end
        @(posedge ap_clk);
        response_valid <= 1'b0;
        sent_count++;
        if (exp_q.size() < 16) begin
            exp_q.push_back(expected_record(words));
        end
    endtask

    task automatic wait_writes();
        int cycles = 0;
        while (done_pulses < sent_count && cycles < 50) begin
            @(posedge ap_clk);
            cycles++;
        end
        if (done_pulses < sent_count) begin
            other_errors++;
            $display("timed out waiting for records to finish in %s", current_test);
        end
    endtask

    task automatic drain_records(input int count, input bit single);
        int target = beats_seen + count;
        int cycles = 0;
        @(posedge ap_clk);
        cfg_rd_en <= 1'b1;
        if (single) begin
            @(posedge ap_clk);
            cfg_rd_en <= 1'b0;
        end
        while (beats_seen < target && cycles < 100) begin
            @(posedge ap_clk);
            cycles++;
        end
        cfg_rd_en <= 1'b0;
        if (beats_seen < target) begin
            other_errors++;
            $display("timed out waiting for cfg_valid beats in %s", current_test);
        end
        repeat (4) @(posedge ap_clk);
        @(negedge ap_clk);
        expect_bit("fifo_empty", 1'b1, fifo_empty);
        expect_bit("all records returned", 1'b1, exp_q.size() == 0);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        int cycles = 0;
        response_valid  <= 1'b0;
        response_offset <= '0;
        response_data   <= '0;
        cfg_rd_en       <= 1'b0;
        // Setup flag is held while reset is asserted
        @(negedge ap_clk);
        expect_bit("fifo_setup", 1'b1, fifo_setup);
        while (areset_csr_index_generator !== 1'b0 && cycles < 20) begin
            @(posedge ap_clk);
            cycles++;
        end
        if (areset_csr_index_generator !== 1'b0) begin
            other_errors++;
            $display("timed out waiting for reset release");
        end
        @(negedge ap_clk);
        expect_bit("cfg_valid", 1'b0, cfg_valid);
        expect_bit("fifo_empty", 1'b1, fifo_empty);
        expect_bit("fifo_full", 1'b0, fifo_full);
        cycles = 0;
        while (fifo_setup && cycles < 4) begin
            @(negedge ap_clk);
            cycles++;
        end
        expect_bit("fifo_setup", 1'b0, fifo_setup);

        current_test = "single";
        send_sequence(1'b0);
        wait_writes();
        drain_records(1, 1'b1);

        current_test = "noise";
        send_sequence(1'b1);
        wait_writes();
        drain_records(1, 1'b1);

        current_test = "ordered";
        repeat (4) send_sequence(1'b1);
        wait_writes();
        drain_records(4, 1'b0);

        // Seventeenth record meets a full FIFO and is lost
        current_test = "overflow";
        repeat (17) send_sequence(1'b0);
        wait_writes();
        @(negedge ap_clk);
        expect_bit("fifo_full", 1'b1, fifo_full);
        drain_records(16, 1'b0);

        $display("value errors %0d, other errors %0d", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_csr_index_configure_memory

//--- filelist.f
csr_index_mem_pkg.sv
csr_index_cfg_pkg.sv
csr_index_response_filter.sv
csr_index_sequence_tracker.sv
csr_index_field_decoder.sv
csr_index_config_fifo.sv
csr_index_configure_memory.sv
tb_clock_gen.sv
tb_csr_index_configure_memory.sv

//--- Makefile
TOP = tb_csr_index_configure_memory

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f filelist.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log
